//--- verilog/pdp8_isa_pkg.sv
/*
 * pdp8 instruction set definitions
 * word type, the two views of an instruction word, opcodes and codes
 */
package pdp8_isa_pkg;

    typedef logic [0:11] word_t;  // bit 0 is the msb

    typedef struct packed {
        logic [0:2] opcode;
        logic       indirect;
        logic       page;         // current page when set
        logic [0:6] addr;
    } mem_ref_t;

    // micro-op bits 4..11 are uop, code and uop11
    typedef struct packed {
        logic [0:3] prefix;       // group select
        logic [4:7] uop;
        logic [0:2] code;         // bits 8-10, rotate or eae code
        logic       uop11;
    } operate_t;

    typedef union packed {
        word_t    word;
        mem_ref_t mem;
        operate_t opr;
    } instr_u;

    localparam logic [2:0] OPC_AND = 3'o0;
    localparam logic [2:0] OPC_TAD = 3'o1;
    localparam logic [2:0] OPC_DCA = 3'o3;

    localparam logic [3:0] GROUP1_PREFIX = 4'b1110;
    localparam logic [3:0] GROUP3_PREFIX = 4'b1111;  // with bit 11 set

    localparam logic [2:0] ROT_BSW = 3'b001;
    localparam logic [2:0] ROT_RAL = 3'b010;
    localparam logic [2:0] ROT_RTL = 3'b011;
    localparam logic [2:0] ROT_RAR = 3'b100;
    localparam logic [2:0] ROT_RTR = 3'b101;

    localparam logic [2:0] EAE_SHL = 3'd5;  // 7413
    localparam logic [2:0] EAE_ASR = 3'd6;  // 7415
    localparam logic [2:0] EAE_LSR = 3'd7;  // 7417

endpackage

//--- verilog/pdp8_ac_pkg.sv
/*
 * accumulator unit datapath constants
 * widths, shift limits and the operation classes
 */
package pdp8_ac_pkg;

    localparam int WORD_W = 12;
    localparam int SC_W   = 5;     // eae step count from operand bits 7-11

    // counts at or above this give the saturated result in one step
    localparam int unsigned SHIFT_LIMIT = 24;

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,  // completes without touching registers
        OP_AND    = 3'd1,
        OP_TAD    = 3'd2,
        OP_DCA    = 3'd3,
        OP_GROUP1 = 3'd4,
        OP_GROUP3 = 3'd5,
        OP_SHIFT  = 3'd6
    } op_class_e;

endpackage

//--- verilog/ac_instr_decode.sv
`timescale 1ns/1ps
/*
 * instruction decode
 * latches the word on an accepted start, classifies it and issues a cycle later
 */
module ac_instr_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  pdp8_isa_pkg::word_t          instruction,
    input  pdp8_isa_pkg::word_t          operand,
    input  logic                         busy,
    output logic                         issue,
    output pdp8_ac_pkg::op_class_e       op_class,
    output pdp8_isa_pkg::word_t          op_operand,
    output logic                         cla,
    output logic                         cll,
    output logic                         cma,
    output logic                         cml,
    output logic                         iac,
    output logic                         mqa,
    output logic                         mql,
    output logic [2:0]                   rot_code,
    output logic [2:0]                   shift_code,
    output logic [pdp8_ac_pkg::SC_W-1:0] shift_count
);
    import pdp8_isa_pkg::*;
    import pdp8_ac_pkg::*;

    instr_u iw;
    word_t  operand_q;
    logic   pending;     // word captured, issue next edge
    logic   is_g1;
    logic   is_g3;

    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            iw.word   <= instruction;
            operand_q <= operand;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= 1'b0;
            issue   <= 1'b0;
        end
        else
        begin
            pending <= start && !busy;
            issue   <= pending;
        end
    end

    // memory reference view first, operate view for the rest
    always_comb
    begin
        op_class = OP_NONE;
        case (iw.mem.opcode)
            OPC_AND: op_class = OP_AND;
            OPC_TAD: op_class = OP_TAD;
            OPC_DCA: op_class = OP_DCA;
            default:
            begin
                if (iw.opr.prefix == GROUP1_PREFIX)
                    op_class = OP_GROUP1;
                else if (iw.opr.prefix == GROUP3_PREFIX && iw.opr.uop11)
                begin
                    if (iw.opr.code inside {EAE_SHL, EAE_ASR, EAE_LSR})
                        op_class = OP_SHIFT;
                    else if (iw.opr.code == 3'b000 && !iw.opr.uop[6])  // no sca
                        op_class = OP_GROUP3;
                end
            end
        endcase
    end

    assign is_g1 = (op_class == OP_GROUP1);
    assign is_g3 = (op_class == OP_GROUP3);

    assign cla = (is_g1 || is_g3) && iw.opr.uop[4];
    assign cll = is_g1 && iw.opr.uop[5];
    assign cma = is_g1 && iw.opr.uop[6];
    assign cml = is_g1 && iw.opr.uop[7];
    assign iac = is_g1 && iw.opr.uop11;
    assign mqa = is_g3 && iw.opr.uop[5];
    assign mql = is_g3 && iw.opr.uop[7];

    assign rot_code    = is_g1 ? iw.opr.code : 3'b000;
    assign shift_code  = iw.opr.code;
    assign shift_count = operand_q[7:11];  // low five bits of the count word
    assign op_operand  = operand_q;

endmodule

//--- verilog/ac_operate_unit.sv
`timescale 1ns/1ps
/*
 * single pass execute
 * memory reference, group 1 and group 3 results for link, ac and mq
 */
module ac_operate_unit (
    input  pdp8_ac_pkg::op_class_e op_class,
    input  pdp8_isa_pkg::word_t    op_operand,
    input  logic                   cla,
    input  logic                   cll,
    input  logic                   cma,
    input  logic                   cml,
    input  logic                   iac,
    input  logic                   mqa,
    input  logic                   mql,
    input  logic [2:0]             rot_code,
    input  logic                   link,
    input  pdp8_isa_pkg::word_t    ac,
    input  pdp8_isa_pkg::word_t    mq,
    output logic                   next_link,
    output pdp8_isa_pkg::word_t    next_ac,
    output pdp8_isa_pkg::word_t    next_mq
);
    import pdp8_isa_pkg::*;
    import pdp8_ac_pkg::*;

    logic [WORD_W:0] tad_sum;
    logic            g1_link;
    word_t           g1_ac;
    logic            rot_link;
    word_t           rot_ac;
    word_t           g3_t;

    assign tad_sum = {link, ac} + {1'b0, op_operand};  // carry flips the link

    // clear, complement, increment, then rotate
    always_comb
    begin
        g1_ac   = cla ? '0 : ac;
        g1_link = cll ? 1'b0 : link;
        if (cma)
            g1_ac = ~g1_ac;
        if (cml)
            g1_link = ~g1_link;
        if (iac)
            {g1_link, g1_ac} = {g1_link, g1_ac} + 1'b1;
        case (rot_code)
            ROT_BSW: {rot_link, rot_ac} = {g1_link, g1_ac[6:11], g1_ac[0:5]};
            ROT_RAL: {rot_link, rot_ac} = {g1_ac, g1_link};
            ROT_RTL: {rot_link, rot_ac} = {g1_ac[1:11], g1_link, g1_ac[0]};
            ROT_RAR: {rot_link, rot_ac} = {g1_ac[11], g1_link, g1_ac[0:10]};
            ROT_RTR: {rot_link, rot_ac} = {g1_ac[10:11], g1_link, g1_ac[0:9]};
            default: {rot_link, rot_ac} = {g1_link, g1_ac};
        endcase
    end

    assign g3_t = cla ? '0 : ac;

    always_comb
    begin
        next_link = link;
        next_ac   = ac;
        next_mq   = mq;
        case (op_class)
            OP_AND:    next_ac = ac & op_operand;
            OP_TAD:    {next_link, next_ac} = tad_sum;
            OP_DCA:    next_ac = '0;  // store happens outside
            OP_GROUP1: {next_link, next_ac} = {rot_link, rot_ac};
            OP_GROUP3:
            begin
                next_ac = (mqa ? mq : '0) | (mql ? '0 : g3_t);
                next_mq = mql ? g3_t : mq;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/eae_shift_unit.sv
`timescale 1ns/1ps
/*
 * eae mode A shift engine
 * SHL, ASR and LSR over link, ac and mq, one place per cycle
 * counts at or above the limit load the saturated value in one step
 */
module eae_shift_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue,
    input  pdp8_ac_pkg::op_class_e       op_class,
    input  logic [2:0]                   shift_code,
    input  logic [pdp8_ac_pkg::SC_W-1:0] shift_count,
    input  logic                         link,
    input  pdp8_isa_pkg::word_t          ac,
    input  pdp8_isa_pkg::word_t          mq,
    output logic                         shift_done,
    output logic                         shift_link,
    output pdp8_isa_pkg::word_t          shift_ac,
    output pdp8_isa_pkg::word_t          shift_mq
);
    import pdp8_isa_pkg::*;
    import pdp8_ac_pkg::*;

    logic            launch;
    logic            saturate;
    logic            sat_neg;
    logic            active;
    logic [SC_W-1:0] steps_left;

    // one place of movement, returns {link, ac, mq}
    function automatic logic [0:2*WORD_W] shift_step(input logic [2:0] code,
                                                      input word_t a,
                                                      input word_t m);
        case (code)
            EAE_SHL: shift_step = {a, m, 1'b0};
            EAE_ASR: shift_step = {a[0], a[0], a, m[0:WORD_W-2]};  // sign fill
            default: shift_step = {2'b00, a, m[0:WORD_W-2]};
        endcase
    endfunction

    assign launch   = issue && (op_class == OP_SHIFT);
    assign saturate = (shift_count >= SHIFT_LIMIT);
    assign sat_neg  = (shift_code == EAE_ASR) && ac[0];

    // first step happens on the launch edge itself, from the live registers
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            if (saturate)
                {shift_link, shift_ac, shift_mq} <= {(2*WORD_W+1){sat_neg}};
            else
                {shift_link, shift_ac, shift_mq} <= shift_step(shift_code, ac, mq);
        end
        else if (active)
            {shift_link, shift_ac, shift_mq} <= shift_step(shift_code, shift_ac, shift_mq);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active     <= 1'b0;
            steps_left <= '0;
            shift_done <= 1'b0;
        end
        else if (launch)
        begin
            steps_left <= shift_count;
            active     <= !saturate && (shift_count != '0);
            shift_done <= saturate || (shift_count == '0);
        end
        else if (active)
        begin
            steps_left <= steps_left - 1'b1;
            active     <= (steps_left != 1);
            shift_done <= (steps_left == 1);  // last place moved
        end
        else
            shift_done <= 1'b0;
    end

endmodule

//--- verilog/ac_result_reg.sv
`timescale 1ns/1ps
/*
 * architectural registers
 * link, ac and mq with write-back select, plus busy and done
 */
module ac_result_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   issue,
    input  logic                   shift_done,
    input  pdp8_ac_pkg::op_class_e op_class,
    input  logic                   next_link,
    input  pdp8_isa_pkg::word_t    next_ac,
    input  pdp8_isa_pkg::word_t    next_mq,
    input  logic                   shift_link,
    input  pdp8_isa_pkg::word_t    shift_ac,
    input  pdp8_isa_pkg::word_t    shift_mq,
    output logic                   link,
    output pdp8_isa_pkg::word_t    ac,
    output pdp8_isa_pkg::word_t    mq,
    output logic                   busy,
    output logic                   done
);
    import pdp8_ac_pkg::*;

    logic op_write;

    assign op_write = issue && (op_class != OP_SHIFT);  // shifts wait for the engine

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            link <= 1'b0;
            ac   <= '0;
            mq   <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            if (op_write)
                {link, ac, mq} <= {next_link, next_ac, next_mq};
            else if (shift_done)
                {link, ac, mq} <= {shift_link, shift_ac, shift_mq};
            done <= op_write || shift_done;
            if (start && !busy)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;  // drops as done falls
        end
    end

endmodule

//--- verilog/pdp8_ac_top.sv
`timescale 1ns/1ps
/*
 * pdp8 accumulator unit
 * decode, single pass execute, eae shifter and register write-back
 */
module pdp8_ac_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  pdp8_isa_pkg::word_t instruction,
    input  pdp8_isa_pkg::word_t operand,
    output logic                link,
    output pdp8_isa_pkg::word_t ac,
    output pdp8_isa_pkg::word_t mq,
    output logic                busy,
    output logic                done
);
    import pdp8_isa_pkg::*;
    import pdp8_ac_pkg::*;

    logic            issue;
    op_class_e       op_class;
    word_t           op_operand;
    logic            cla;
    logic            cll;
    logic            cma;
    logic            cml;
    logic            iac;
    logic            mqa;
    logic            mql;
    logic [2:0]      rot_code;
    logic [2:0]      shift_code;
    logic [SC_W-1:0] shift_count;
    logic            next_link;
    word_t           next_ac;
    word_t           next_mq;
    logic            shift_done;
    logic            shift_link;
    word_t           shift_ac;
    word_t           shift_mq;

    ac_instr_decode i_decode (
        .clk(clk), .rst(rst), .start(start), .instruction(instruction),
        .operand(operand), .busy(busy), .issue(issue), .op_class(op_class),
        .op_operand(op_operand), .cla(cla), .cll(cll), .cma(cma), .cml(cml),
        .iac(iac), .mqa(mqa), .mql(mql), .rot_code(rot_code),
        .shift_code(shift_code), .shift_count(shift_count)
    );

    ac_operate_unit i_operate (
        .op_class(op_class), .op_operand(op_operand), .cla(cla), .cll(cll),
        .cma(cma), .cml(cml), .iac(iac), .mqa(mqa), .mql(mql),
        .rot_code(rot_code), .link(link), .ac(ac), .mq(mq),
        .next_link(next_link), .next_ac(next_ac), .next_mq(next_mq)
    );

    eae_shift_unit i_shift (
        .clk(clk), .rst(rst), .issue(issue), .op_class(op_class),
        .shift_code(shift_code), .shift_count(shift_count), .link(link),
        .ac(ac), .mq(mq), .shift_done(shift_done), .shift_link(shift_link),
        .shift_ac(shift_ac), .shift_mq(shift_mq)
    );

    ac_result_reg i_result (
        .clk(clk), .rst(rst), .start(start), .issue(issue),
        .shift_done(shift_done), .op_class(op_class), .next_link(next_link),
        .next_ac(next_ac), .next_mq(next_mq), .shift_link(shift_link),
        .shift_ac(shift_ac), .shift_mq(shift_mq), .link(link), .ac(ac),
        .mq(mq), .busy(busy), .done(done)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
/*
 * testbench clock source, 4 ns period
 */
module tb_clock_gen (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // half period
    end

endmodule

//--- testbench/tb_pdp8_ac.sv
`timescale 1ns/1ps
/*
 * testbench for the pdp8 accumulator unit
 * preloads link, ac and mq with kept instructions, runs each case from the
 * case file with a stray start while busy, then checks the registers
 */
module tb_pdp8_ac;
    import pdp8_isa_pkg::*;

    localparam int    NUM_CASES  = 24;
    localparam int    FIELDS     = 8;        // words per case line
    localparam int    STEP_LIMIT = 40;       // cycles allowed per instruction
    localparam word_t INSTR_TAD  = 12'h200;  // tad 1000
    localparam word_t INSTR_MQL  = 12'hf11;  // mql 7421
    localparam word_t INSTR_CML  = 12'he10;  // cml 7020
    localparam word_t INSTR_CLA  = 12'he80;  // cla 7200, would wipe ac if taken

    logic   clk;
    logic   rst;
    logic   start;
    word_t  instruction;
    word_t  operand;
    logic   link;
    word_t  ac;
    word_t  mq;
    logic   busy;
    logic   done;
    word_t  case_mem [0:NUM_CASES*FIELDS-1];
    integer seed          = 32'h7a9b;
    int     cycle_count   = 0;
    int     timeout_limit = 0;
    int     pass_count    = 0;
    int     fail_count    = 0;

    tb_clock_gen i_clock (.clk(clk));

    pdp8_ac_top i_pdp8_ac_top (
        .clk(clk), .rst(rst), .start(start), .instruction(instruction),
        .operand(operand), .link(link), .ac(ac), .mq(mq), .busy(busy), .done(done)
    );

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit)
        begin
            $display("timeout after %0d cycles, the DUT never finished", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic idle_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk);
    endtask

    // start to done, busy must hold until done and drop right after it
    task automatic execute(input word_t instr, input word_t data, input bit stray,
                           output logic ok);
        bit seen_done;
        ok = 1'b1;
        seen_done = 1'b0;
        @(negedge clk);
        start = 1'b1;
        instruction = instr;
        operand = data;
        @(negedge clk);
        if (stray)
            instruction = INSTR_CLA;  // second start lands while busy
        else
            start = 1'b0;
        while (!seen_done)
        begin
            if (!busy && ok)
            begin
                $display("Error: time %0t: busy went low before done came", $time);
                ok = 1'b0;
            end
            seen_done = done;
            @(negedge clk);
            start = 1'b0;
        end
        if (busy)
        begin
            $display("Error: time %0t: busy still high after done fell", $time);
            ok = 1'b0;
        end
    endtask

    task automatic run_case(input int idx);
        int   base;
        logic ok;
        logic all_ok;
        logic exp_link;
        base = idx * FIELDS;
        all_ok = 1'b1;
        apply_reset();
        execute(INSTR_TAD, case_mem[base+2], 1'b0, ok);  // mq value into ac
        all_ok = all_ok & ok;
        execute(INSTR_MQL, 12'h000, 1'b0, ok);
        all_ok = all_ok & ok;
        execute(INSTR_TAD, case_mem[base+1], 1'b0, ok);
        all_ok = all_ok & ok;
        if (case_mem[base][11])
        begin
            execute(INSTR_CML, 12'h000, 1'b0, ok);
            all_ok = all_ok & ok;
        end
        idle_cycles();
        execute(case_mem[base+3], case_mem[base+4], 1'b1, ok);
        all_ok = all_ok & ok;
        exp_link = case_mem[base+5][11];
        if (link !== exp_link || ac !== case_mem[base+6] || mq !== case_mem[base+7])
        begin
            $display("Error: time %0t case %0d: got link %0d ac %03h mq %03h,",
                     $time, idx, link, ac, mq);
            $display("       expected link %0d ac %03h mq %03h",
                     exp_link, case_mem[base+6], case_mem[base+7]);
            all_ok = 1'b0;
        end
        if (all_ok)
            pass_count++;
        else
            fail_count++;
        $display("case %0d instruction %03h: %s", idx, case_mem[base+3],
                 all_ok ? "ok" : "failed");
        idle_cycles();
    endtask

    initial
    begin
        rst = 1'b1;
        start = 1'b0;
        instruction = '0;
        operand = '0;
        $readmemh("testbench/pdp8_ac_cases.txt", case_mem);
        // reset, three preload steps, optional cml, then the case itself
        for (int i = 0; i < NUM_CASES; i++)
            timeout_limit += STEP_LIMIT * (case_mem[i*FIELDS][11] ? 6 : 5);
        for (int i = 0; i < NUM_CASES; i++)
            run_case(i);
        $display("%0d cases: %0d passed, %0d failed", NUM_CASES, pass_count, fail_count);
        if (fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- pdp8_ac.f
verilog/pdp8_isa_pkg.sv
verilog/pdp8_ac_pkg.sv
verilog/ac_instr_decode.sv
verilog/ac_operate_unit.sv
verilog/eae_shift_unit.sv
verilog/ac_result_reg.sv
verilog/pdp8_ac_top.sv
testbench/tb_clock_gen.sv
testbench/tb_pdp8_ac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the accumulator unit testbench with verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pdp8_ac \
    -f pdp8_ac.f -o sim_pdp8_ac
./obj_dir/sim_pdp8_ac | tee "$LOG"

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation run passed"
    exit 0
fi
echo "simulation run failed, see $LOG"
exit 1

//--- testbench/pdp8_ac_cases.txt
// columns, all hex: link ac mq instruction operand, then expected link ac mq
// shift operand holds the step count in its low five bits
0 f0f 123 000 3c3  0 303 123  // and
0 fff 000 200 001  1 000 000  // tad, carry sets link
1 800 0aa 200 900  0 100 0aa  // tad, carry clears link
1 abc def 600 000  1 000 def  // dca
0 5a5 111 ea0 000  0 fff 111  // cla cma
0 321 000 e50 000  1 321 000  // cll cml
0 fff 000 e01 000  1 000 000  // iac overflow
1 abc 000 e02 000  1 f2a 000  // bsw
1 801 000 e04 000  1 003 000  // ral
0 c00 000 e06 000  1 001 000  // rtl
1 002 000 e08 000  0 801 000  // rar
0 003 000 e0a 000  1 800 000  // rtr
0 777 555 ed5 000  0 003 555  // cla cll cml iac ral
1 246 9ab f11 000  1 000 246  // mql
0 0f0 30c f41 000  0 3fc 30c  // mqa
0 123 456 f51 000  0 456 123  // swp
1 777 a5a fc1 000  1 a5a a5a  // acl
0 6b1 222 f91 000  0 000 000  // cla mql
0 123 f81 f0b 003  1 23f 810  // shl 4 places
1 345 678 f0d 004  0 01a 2b3  // asr positive, 5 places
0 c00 00f f0d 002  1 f80 001  // asr negative, 3 places
1 fff 000 f0f 005  0 03f fc0  // lsr 6 places
1 fff fff f0b 018  0 000 000  // shl count 24, saturated
0 800 000 f0d 01f  1 fff fff  // asr negative count 31, saturated
